//--- Bender.yml
package:
  name: npc

sources:
  - logic/npc_pkg.sv
  - logic/npc_idu.sv
  - logic/npc_gpr.sv
  - logic/npc_exu.sv
  - logic/npc_pc.sv
  - logic/npc_datamem.sv
  - logic/npc_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/npc_tb.sv

//--- dv/npc_ref.svh
// Uses npc_tb state (m_reg, m_mem, m_pc, imem, lfsr); include in npc_tb only
`ifndef NPC_REF_SVH
`define NPC_REF_SVH

function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int k = 0; k < n; k++) begin
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // x^32+x^22+x^2+x+1
    r    = {r[30:0], lfsr[0]};
  end
  return r;
endfunction

function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, npc_pkg::OPC_OP};
endfunction

function automatic logic [31:0] s_type(input logic [4:0] rs1, rs2, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'd3, imm[4:0], npc_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], npc_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, npc_pkg::OPC_JAL};
endfunction

// Bit 64 marks a funct3 outside the subset
function automatic logic [64:0] alu_ref(input logic [2:0] f3, input logic [63:0] x, y);
  case (f3)
    3'd0:    return {1'b0, x + y};
    3'd2:    return {1'b0, 63'd0, $signed(x) < $signed(y)};
    3'd3:    return {1'b0, 63'd0, x < y};
    3'd4:    return {1'b0, x ^ y};
    3'd6:    return {1'b0, x | y};
    3'd7:    return {1'b0, x & y};
    default: return {1'b1, 64'd0};
  endcase
endfunction

// Applies one instruction to the model state and returns the expected retire fields
function automatic void ref_step(input logic [31:0] w, output logic ill, wen,
                                 output logic [63:0] wd);
  logic [63:0] a, b, ii, ib, addr, npc;
  logic [64:0] r;
  logic        tk;
  a   = m_reg[w[19:15]];
  b   = m_reg[w[24:20]];
  ii  = {{52{w[31]}}, w[31:20]};
  ib  = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  npc = m_pc + 64'd4;
  ill = 1'b0;
  wen = 1'b1;
  wd  = '0;
  tk  = 1'b0;
  case (w[6:0])
    npc_pkg::OPC_LUI:   wd = {{32{w[31]}}, w[31:12], 12'd0};
    npc_pkg::OPC_AUIPC: wd = m_pc + {{32{w[31]}}, w[31:12], 12'd0};
    npc_pkg::OPC_JAL: begin
      wd  = npc;
      npc = m_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
    npc_pkg::OPC_JALR: begin
      wd  = npc;
      ill = (w[14:12] != 3'd0);
      npc = (a + ii) & ~64'd1;
    end
    npc_pkg::OPC_BRANCH: begin
      wen = 1'b0;
      case (w[14:12])
        3'd0:    tk = (a == b);
        3'd1:    tk = (a != b);
        3'd4:    tk = ($signed(a) < $signed(b));
        3'd5:    tk = ($signed(a) >= $signed(b));
        3'd6:    tk = (a < b);
        3'd7:    tk = (a >= b);
        default: ill = 1'b1;
      endcase
      if (tk) begin
        npc = m_pc + ib;
      end
    end
    npc_pkg::OPC_LOAD: begin
      addr = a + ii;
      ill  = (w[14:12] != 3'd3);
      wd   = m_mem[addr[7:3]];                          // Only bits 7:3 select the doubleword
    end
    npc_pkg::OPC_STORE: begin
      addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
      wen  = 1'b0;
      ill  = (w[14:12] != 3'd3);
      if (!ill) begin
        m_mem[addr[7:3]] = b;
      end
    end
    npc_pkg::OPC_OP_IMM: begin
      r   = alu_ref(w[14:12], a, ii);
      ill = r[64];
      wd  = r[63:0];
    end
    npc_pkg::OPC_OP: begin
      r   = alu_ref(w[14:12], a, b);
      ill = r[64] || (w[31:25] != 7'd0);
      wd  = r[63:0];
      if (w[31:25] == 7'h20 && w[14:12] == 3'd0) begin
        ill = 1'b0;
        wd  = a - b;
      end
    end
    default: ill = 1'b1;
  endcase
  if (ill) begin
    wen = 1'b0;
    npc = m_pc + 64'd4;
  end
  if (wen && w[11:7] != 5'd0) begin
    m_reg[w[11:7]] = wd;
  end
  m_pc = npc;
endfunction

// Fills imem from word first with legal random instructions; word 255 jumps back to first
task automatic fill_random(input int first);
  int          i;
  logic [3:0]  k;
  logic [4:0]  rd, r1, r2;
  logic [2:0]  f3;
  logic [11:0] im;
  logic [19:0] u20;
  i = first;
  while (i < 255) begin
    k   = 4'(lfsr_bits(4));
    rd  = 5'(lfsr_bits(5));
    r1  = 5'(lfsr_bits(5));
    r2  = 5'(lfsr_bits(5));
    f3  = 3'(lfsr_bits(3));
    im  = 12'(lfsr_bits(12));
    u20 = 20'(lfsr_bits(20));
    if (f3 == 3'd1 || f3 == 3'd5) begin
      f3 = 3'd0;                                        // Shift slots
    end
    if (im[4:0] == 5'd0) begin
      im[0] = 1'b1;                                     // No self loops
    end
    if (i > 222 && k >= 4'd11 && k <= 4'd14) begin
      k = 4'd3;                                         // Targets stay inside the array
    end
    case (k)
      4'd0, 4'd1: imem[i] = {u20, rd, npc_pkg::OPC_LUI};
      4'd2:       imem[i] = {u20, rd, npc_pkg::OPC_AUIPC};
      4'd6, 4'd7, 4'd8:
        imem[i] = r_type((f3 == 3'd0 && im[5]) ? 7'h20 : 7'h00, f3, rd, r1, r2);
      4'd9:       imem[i] = i_type(npc_pkg::OPC_LOAD, 3'd3, rd, r1, im);
      4'd10:      imem[i] = s_type(r1, r2, im);
      4'd11, 4'd12:
        imem[i] = b_type((f3 == 3'd2 || f3 == 3'd3) ? f3 - 3'd2 : f3, r1, r2,
                         {{6{im[4]}}, im[4:0], 2'b00});
      4'd13:      imem[i] = j_type(rd, {13'd0, {1'b0, im[4:0]} + 6'd1, 2'b00});
      4'd14: begin
        if (r1 == 5'd0) begin
          r1 = 5'd1;
        end
        imem[i] = {20'd0, r1, npc_pkg::OPC_AUIPC};
        i = i + 1;
        imem[i] = i_type(npc_pkg::OPC_JALR, 3'd0, rd, r1, {6'd0, im[3:0] | 4'd2, 2'b01});
      end
      default:    imem[i] = i_type(npc_pkg::OPC_OP_IMM, f3, rd, r1, im);
    endcase
    i = i + 1;
  end
  imem[255] = j_type(5'd0, 21'((first - 255) * 4));
endtask

`endif

//--- dv/npc_tb.sv
// Program of 256 words at RESET_PC; data memory state carries over between runs, registers do not
`timescale 1ns/100ps
`default_nettype none

module npc_tb;

  localparam int RAND_RUNS = 8;
  localparam int RAND_LEN  = 250;
  localparam int TOTAL     = 20 + 44 + 98 + 40 + RAND_RUNS * RAND_LEN;
  localparam int RUNS      = 4 + RAND_RUNS;
  localparam logic [31:0] NOP = 32'h0000_0013;          // addi x0,x0,0

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic [63:0] o_pc, o_ret_pc, o_ret_wdata;
  logic [31:0] o_ret_inst;
  logic [4:0]  o_ret_rd;
  logic        o_ret_valid, o_ret_illegal, o_ret_wen;

  logic [31:0] imem [256];
  logic [63:0] m_reg [32];
  logic [63:0] m_mem [npc_pkg::DMEM_DEPTH];
  logic [63:0] m_pc;
  logic [31:0] lfsr = 32'h79c1_9388;
  int          errs, n_ret, n_total, n_tests, pl;
  int          n_rel;
  logic [31:0] cw;
  logic        e_ill, e_wen;
  logic [63:0] e_wd;

  `include "npc_ref.svh"

  npc_top UUT (
    .i_clk(clk), .i_rst_n(rst_n), .i_inst(inst),
    .o_pc(o_pc), .o_ret_valid(o_ret_valid), .o_ret_pc(o_ret_pc), .o_ret_inst(o_ret_inst),
    .o_ret_illegal(o_ret_illegal), .o_ret_wen(o_ret_wen), .o_ret_rd(o_ret_rd),
    .o_ret_wdata(o_ret_wdata)
  );

  assign inst = ((o_pc >> 10) == (npc_pkg::RESET_PC >> 10) && o_pc[1:0] == 2'b00) ?
                imem[o_pc[9:2]] : NOP;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #((TOTAL + 20 * RUNS) * 100);
    $display("Watchdog timeout: the tests did not finish in the expected time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] fetch(input logic [63:0] pc);
    if ((pc >> 10) == (npc_pkg::RESET_PC >> 10) && pc[1:0] == 2'b00) begin
      return imem[pc[9:2]];
    end
    return NOP;
  endfunction

  function automatic logic known_opcode(input logic [6:0] op);
    case (op)
      npc_pkg::OPC_LUI, npc_pkg::OPC_AUIPC, npc_pkg::OPC_JAL, npc_pkg::OPC_JALR,
      npc_pkg::OPC_BRANCH, npc_pkg::OPC_LOAD, npc_pkg::OPC_STORE, npc_pkg::OPC_OP_IMM,
      npc_pkg::OPC_OP: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  task automatic put(input logic [31:0] w);
    imem[pl] = w;
    pl++;
  endtask

  task automatic clear_imem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP;
    end
    pl = 0;
  endtask

  // Enters with reset asserted and leaves with it asserted again
  task automatic run_program(input string name, input int n);
    int e0;
    e0 = errs;
    repeat (10) @(posedge clk);
    m_pc = npc_pkg::RESET_PC;
    for (int k = 0; k < 32; k++) begin
      m_reg[k] = '0;
    end
    n_ret = 0;
    rst_n <= 1'b1;
    wait (n_ret >= n);
    @(posedge clk);
    rst_n <= 1'b0;
    n_total += n;
    n_tests++;
    $display("%-8s %0d instructions, %0d errors", name, n, errs - e0);
  endtask

  // Retire fields are stable at the falling edge and commit at the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      check("o_ret_valid", o_ret_valid, 1'b0);
      n_rel = 0;
    end else begin
      check("o_ret_valid", o_ret_valid, n_rel > 0);     // First retire one cycle after release
      n_rel++;
      if (o_ret_valid) begin
        cw = fetch(m_pc);
        check("o_pc", o_pc, m_pc);
        check("o_ret_pc", o_ret_pc, m_pc);
        check("o_ret_inst", o_ret_inst, cw);
        check("o_ret_rd", o_ret_rd, cw[11:7]);
        ref_step(cw, e_ill, e_wen, e_wd);
        check("o_ret_illegal", o_ret_illegal, e_ill);
        check("o_ret_wen", o_ret_wen, e_wen);
        if (e_wen) begin
          check("o_ret_wdata", o_ret_wdata, e_wd);
        end
        n_ret++;
      end
    end
  end

  initial begin
    rst_n   = 1'b0;
    errs    = 0;
    n_ret   = 0;
    n_rel   = 0;
    n_total = 0;
    n_tests = 0;
    clear_imem();
    put({20'h80001, 5'd1, npc_pkg::OPC_LUI});
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd1, 12'hffb));
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'h007));
    put({20'h12345, 5'd3, npc_pkg::OPC_LUI});
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd3, 5'd3, 12'h678));
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) begin
        put(i_type(npc_pkg::OPC_OP_IMM, 3'(f), 5'(10 + f), 5'd1, 12'h8f0));
        put(r_type(7'h00, 3'(f), 5'(20 + f), 5'd2, 5'd3));
      end
    end
    put(r_type(7'h20, 3'd0, 5'd6, 5'd1, 5'd3));
    put(r_type(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));         // Write to x0 is dropped
    put(r_type(7'h00, 3'd0, 5'd7, 5'd0, 5'd0));
    run_program("alu", pl);

    clear_imem();
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'hfff));
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'h001));
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        for (int p = 0; p < 3; p++) begin
          put(b_type(3'(f), (p == 1) ? 5'd2 : 5'd1, (p == 0) ? 5'd2 : 5'd1, 13'd8));
          put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd10, 5'd10, 12'h001));
        end
      end
    end
    put(j_type(5'd5, 21'd8));
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd11, 5'd0, 12'h001));
    put({20'd0, 5'd6, npc_pkg::OPC_AUIPC});
    put(i_type(npc_pkg::OPC_JALR, 3'd0, 5'd7, 5'd6, 12'd13));   // Odd target, bit 0 cleared
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd11, 5'd0, 12'h002));
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd8, 5'd7, 12'h000));
    run_program("branch", pl);

    clear_imem();
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hfff));
    put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd4, 5'd0, 12'h700));   // Bits above 7 ignored
    for (int i = 0; i < 32; i++) begin
      put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd2, 12'h3a5));
      put(s_type(5'd4, 5'd2, 12'(8 * i)));
    end
    for (int j = 0; j < 32; j++) begin
      put(i_type(npc_pkg::OPC_LOAD, 3'd3, 5'd3, 5'd4, 12'(8 * ((j * 13 + 5) % 32) + j % 8)));
    end
    run_program("memory", pl);

    clear_imem();
    for (int i = 0; i < 40; i++) begin
      cw = lfsr_bits(32);
      while (known_opcode(cw[6:0])) begin
        cw[6:0] = 7'(lfsr_bits(7));
      end
      put(cw);
    end
    run_program("illegal", pl);

    for (int r = 0; r < RAND_RUNS; r++) begin
      clear_imem();
      if (r == 0) begin
        for (int i = 0; i < 32; i++) begin
          put(i_type(npc_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd1, 12'(lfsr_bits(12))));
          put(s_type(5'd0, 5'd1, 12'(8 * i)));
        end
      end
      fill_random(pl);
      run_program("random", RAND_LEN);
    end

    $display("tests %0d, instructions %0d, errors %0d", n_tests, n_total, errs);
    if (errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+dv
logic/npc_pkg.sv
logic/npc_idu.sv
logic/npc_gpr.sv
logic/npc_exu.sv
logic/npc_pc.sv
logic/npc_datamem.sv
logic/npc_top.sv
dv/npc_tb.sv

//--- logic/npc_datamem.sv
// Doubleword access only; address bits outside 7:3 are ignored and contents start unknown
`timescale 1ns/100ps
`default_nettype none

module npc_datamem (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst_n,
  input  wire logic [npc_pkg::XLEN-1:0] i_addr,
  input  wire logic [npc_pkg::XLEN-1:0] i_wdata,
  input  wire logic                     i_wen,
  output logic [npc_pkg::XLEN-1:0]      o_rdata
);

  localparam int IW = $clog2(npc_pkg::DMEM_DEPTH);

  logic [npc_pkg::XLEN-1:0] mem [npc_pkg::DMEM_DEPTH];
  logic [IW-1:0]            idx;

  assign idx = i_addr[3 +: IW];                        // Doubleword index

  assign o_rdata = mem[idx];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_rst_n) begin                        // Held off during reset
      mem[idx] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/npc_exu.sv
// Branch flags always compare rs1 with rs2, whatever the ALU operation selected
`timescale 1ns/100ps
`default_nettype none

module npc_exu (
  input  wire logic [npc_pkg::XLEN-1:0] i_rs1_data,
  input  wire logic [npc_pkg::XLEN-1:0] i_rs2_data,
  input  wire logic [npc_pkg::XLEN-1:0] i_imm,
  input  wire logic [npc_pkg::XLEN-1:0] i_pc,
  input  npc_pkg::a_sel_e               i_a_sel,
  input  npc_pkg::b_sel_e               i_b_sel,
  input  npc_pkg::alu_op_e              i_alu_op,
  output logic [npc_pkg::XLEN-1:0]      o_result,
  output logic                          o_less,
  output logic                          o_less_u,
  output logic                          o_zero
);

  localparam int XW = npc_pkg::XLEN;

  logic [XW-1:0] op_a;
  logic [XW-1:0] op_b;
  logic [XW:0]   diff;                                 // Extra bit holds the borrow

  assign op_a = (i_a_sel == npc_pkg::A_PC) ? i_pc : i_rs1_data;

  always_comb begin
    case (i_b_sel)
      npc_pkg::B_IMM:  op_b = i_imm;
      npc_pkg::B_FOUR: op_b = XW'(4);
      default:         op_b = i_rs2_data;
    endcase
  end

  always_comb begin
    case (i_alu_op)
      npc_pkg::ALU_SUB:    o_result = op_a - op_b;
      npc_pkg::ALU_SLT:    o_result = XW'($signed(op_a) < $signed(op_b));
      npc_pkg::ALU_SLTU:   o_result = XW'(op_a < op_b);
      npc_pkg::ALU_AND:    o_result = op_a & op_b;
      npc_pkg::ALU_OR:     o_result = op_a | op_b;
      npc_pkg::ALU_XOR:    o_result = op_a ^ op_b;
      npc_pkg::ALU_PASS_B: o_result = op_b;
      default:             o_result = op_a + op_b;
    endcase
  end

  assign diff     = {1'b0, i_rs1_data} - {1'b0, i_rs2_data};
  assign o_zero   = (diff[XW-1:0] == '0);
  assign o_less_u = diff[XW];
  // Signs differ: rs1 is less when negative; else the difference sign decides
  assign o_less   = (i_rs1_data[XW-1] != i_rs2_data[XW-1]) ? i_rs1_data[XW-1]
                                                            : diff[XW-1];

endmodule

`default_nettype wire

//--- logic/npc_gpr.sv
// x0 is hardwired to zero; reads see the value from before this cycle's write
`timescale 1ns/100ps
`default_nettype none

module npc_gpr (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst_n,
  input  wire logic [4:0]                i_rs1,
  input  wire logic [4:0]                i_rs2,
  input  wire logic [4:0]                i_rd,
  input  wire logic [npc_pkg::XLEN-1:0]  i_wdata,
  input  wire logic                      i_wen,
  output logic [npc_pkg::XLEN-1:0]       o_rs1_data,
  output logic [npc_pkg::XLEN-1:0]       o_rs2_data
);

  logic [npc_pkg::XLEN-1:0] regs [1:31];               // No storage for x0

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- logic/npc_idu.sv
// Decodes the listed RV64I subset only; anything else is illegal and acts as a plain PC+4
`timescale 1ns/100ps
`default_nettype none

module npc_idu (
  input  wire logic [npc_pkg::ILEN-1:0] i_inst,
  output logic [npc_pkg::XLEN-1:0]      o_imm,
  output logic [4:0]                    o_rs1,
  output logic [4:0]                    o_rs2,
  output logic [4:0]                    o_rd,
  output npc_pkg::a_sel_e               o_a_sel,
  output npc_pkg::b_sel_e               o_b_sel,
  output npc_pkg::alu_op_e              o_alu_op,
  output npc_pkg::br_kind_e             o_br_kind,
  output logic                          o_reg_wen,
  output logic                          o_mem_wen,
  output logic                          o_mem_to_reg,
  output logic                          o_illegal
);

  localparam int XW = npc_pkg::XLEN;

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic [XW-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  assign imm_i = {{(XW-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XW-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XW-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XW-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XW-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_imm        = imm_i;
    o_a_sel      = npc_pkg::A_RS1;
    o_b_sel      = npc_pkg::B_IMM;
    o_alu_op     = npc_pkg::ALU_ADD;
    o_br_kind    = npc_pkg::BR_NONE;
    o_reg_wen    = 1'b0;
    o_mem_wen    = 1'b0;
    o_mem_to_reg = 1'b0;
    o_illegal    = 1'b0;
    case (opcode)
      npc_pkg::OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = npc_pkg::ALU_PASS_B;
        o_reg_wen = 1'b1;
      end
      npc_pkg::OPC_AUIPC: begin
        o_imm     = imm_u;
        o_a_sel   = npc_pkg::A_PC;
        o_reg_wen = 1'b1;
      end
      npc_pkg::OPC_JAL: begin
        o_imm     = imm_j;
        o_a_sel   = npc_pkg::A_PC;                      // Link = PC + 4
        o_b_sel   = npc_pkg::B_FOUR;
        o_br_kind = npc_pkg::BR_JAL;
        o_reg_wen = 1'b1;
      end
      npc_pkg::OPC_JALR: begin
        o_a_sel   = npc_pkg::A_PC;
        o_b_sel   = npc_pkg::B_FOUR;
        o_br_kind = npc_pkg::BR_JALR;
        o_reg_wen = 1'b1;
        o_illegal = (funct3 != 3'b000);
      end
      npc_pkg::OPC_BRANCH: begin
        o_imm    = imm_b;
        o_b_sel  = npc_pkg::B_RS2;
        o_alu_op = npc_pkg::ALU_SUB;
        case (funct3)
          3'b000:  o_br_kind = npc_pkg::BR_EQ;
          3'b001:  o_br_kind = npc_pkg::BR_NE;
          3'b100:  o_br_kind = npc_pkg::BR_LT;
          3'b101:  o_br_kind = npc_pkg::BR_GE;
          3'b110:  o_br_kind = npc_pkg::BR_LTU;
          3'b111:  o_br_kind = npc_pkg::BR_GEU;
          default: o_illegal = 1'b1;
        endcase
      end
      npc_pkg::OPC_LOAD: begin
        o_reg_wen    = 1'b1;
        o_mem_to_reg = 1'b1;
        o_illegal    = (funct3 != 3'b011);               // ld only
      end
      npc_pkg::OPC_STORE: begin
        o_imm     = imm_s;
        o_mem_wen = 1'b1;
        o_illegal = (funct3 != 3'b011);                  // sd only
      end
      npc_pkg::OPC_OP_IMM: begin
        o_reg_wen = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = npc_pkg::ALU_ADD;
          3'b010:  o_alu_op = npc_pkg::ALU_SLT;
          3'b011:  o_alu_op = npc_pkg::ALU_SLTU;
          3'b100:  o_alu_op = npc_pkg::ALU_XOR;
          3'b110:  o_alu_op = npc_pkg::ALU_OR;
          3'b111:  o_alu_op = npc_pkg::ALU_AND;
          default: o_illegal = 1'b1;                     // Shifts not supported
        endcase
      end
      npc_pkg::OPC_OP: begin
        o_b_sel   = npc_pkg::B_RS2;
        o_reg_wen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = npc_pkg::ALU_ADD;
          10'b0100000_000: o_alu_op = npc_pkg::ALU_SUB;
          10'b0000000_010: o_alu_op = npc_pkg::ALU_SLT;
          10'b0000000_011: o_alu_op = npc_pkg::ALU_SLTU;
          10'b0000000_100: o_alu_op = npc_pkg::ALU_XOR;
          10'b0000000_110: o_alu_op = npc_pkg::ALU_OR;
          10'b0000000_111: o_alu_op = npc_pkg::ALU_AND;
          default:         o_illegal = 1'b1;
        endcase
      end
      default: o_illegal = 1'b1;
    endcase
    // An illegal word must leave no architectural trace
    if (o_illegal) begin
      o_reg_wen    = 1'b0;
      o_mem_wen    = 1'b0;
      o_mem_to_reg = 1'b0;
      o_br_kind    = npc_pkg::BR_NONE;
    end
  end

endmodule

`default_nettype wire

//--- logic/npc_pc.sv
// PC advances every clock out of reset; jalr target has bit 0 cleared, no alignment trap
`timescale 1ns/100ps
`default_nettype none

module npc_pc (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst_n,
  input  npc_pkg::br_kind_e             i_br_kind,
  input  wire logic [npc_pkg::XLEN-1:0] i_imm,
  input  wire logic [npc_pkg::XLEN-1:0] i_rs1_data,
  input  wire logic                     i_less,
  input  wire logic                     i_less_u,
  input  wire logic                     i_zero,
  output logic [npc_pkg::XLEN-1:0]      o_pc
);

  logic                     take_rel;
  logic [npc_pkg::XLEN-1:0] jalr_tgt;
  logic [npc_pkg::XLEN-1:0] pc_next;

  always_comb begin
    case (i_br_kind)
      npc_pkg::BR_JAL: take_rel = 1'b1;
      npc_pkg::BR_EQ:  take_rel = i_zero;
      npc_pkg::BR_NE:  take_rel = !i_zero;
      npc_pkg::BR_LT:  take_rel = i_less;
      npc_pkg::BR_GE:  take_rel = !i_less;
      npc_pkg::BR_LTU: take_rel = i_less_u;
      npc_pkg::BR_GEU: take_rel = !i_less_u;
      default:         take_rel = 1'b0;
    endcase
  end

  assign jalr_tgt = (i_rs1_data + i_imm) & ~npc_pkg::XLEN'(1);

  assign pc_next = (i_br_kind == npc_pkg::BR_JALR) ? jalr_tgt :
                   take_rel                        ? o_pc + i_imm :
                                                     o_pc + npc_pkg::XLEN'(4);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc <= npc_pkg::RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/npc_pkg.sv
// Fixed RV64I widths and codes; br_kind_e needs 4 bits to hold its nine kinds
`default_nettype none

package npc_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int DMEM_DEPTH = 32;                      // Doublewords

  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
  } alu_op_e;

  // Conditional kinds compare rs1 against rs2
  typedef enum logic [3:0] {
    BR_NONE, BR_JAL, BR_JALR,
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_kind_e;

  typedef enum logic {
    A_RS1, A_PC
  } a_sel_e;

  typedef enum logic [1:0] {
    B_RS2, B_IMM, B_FOUR
  } b_sel_e;

endpackage

`default_nettype wire

//--- logic/npc_top.sv
// Fetch is combinational with no stall; first retirement comes one cycle after reset release
`timescale 1ns/100ps
`default_nettype none

module npc_top (
  input  wire logic                     i_clk,
  input  wire logic                     i_rst_n,
  input  wire logic [npc_pkg::ILEN-1:0] i_inst,
  output logic [npc_pkg::XLEN-1:0]      o_pc,
  output logic                          o_ret_valid,
  output logic [npc_pkg::XLEN-1:0]      o_ret_pc,
  output logic [npc_pkg::ILEN-1:0]      o_ret_inst,
  output logic                          o_ret_illegal,
  output logic                          o_ret_wen,
  output logic [4:0]                    o_ret_rd,
  output logic [npc_pkg::XLEN-1:0]      o_ret_wdata
);

  logic [npc_pkg::XLEN-1:0] imm, rs1_data, rs2_data, alu_result, mem_rdata, wb_data;
  logic [4:0]               rs1, rs2, rd;
  npc_pkg::a_sel_e          a_sel;
  npc_pkg::b_sel_e          b_sel;
  npc_pkg::alu_op_e         alu_op;
  npc_pkg::br_kind_e        br_kind;
  logic                     reg_wen, mem_wen, mem_to_reg, illegal;
  logic                     less, less_u, zero;
  logic                     ret_valid;

  // Also the core reset: asserts with i_rst_n, releases on the next clock
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= 1'b1;
    end
  end

  npc_idu u_idu (
    .i_inst(i_inst),
    .o_imm(imm),
    .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd),
    .o_a_sel(a_sel), .o_b_sel(b_sel), .o_alu_op(alu_op),
    .o_br_kind(br_kind),
    .o_reg_wen(reg_wen), .o_mem_wen(mem_wen), .o_mem_to_reg(mem_to_reg),
    .o_illegal(illegal)
  );

  npc_gpr u_gpr (
    .i_clk(i_clk), .i_rst_n(ret_valid),
    .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
    .i_wdata(wb_data), .i_wen(reg_wen),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  npc_exu u_exu (
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_imm(imm), .i_pc(o_pc),
    .i_a_sel(a_sel), .i_b_sel(b_sel), .i_alu_op(alu_op),
    .o_result(alu_result),
    .o_less(less), .o_less_u(less_u), .o_zero(zero)
  );

  npc_pc u_pc (
    .i_clk(i_clk), .i_rst_n(ret_valid),                // Holds RESET_PC until first retire
    .i_br_kind(br_kind), .i_imm(imm), .i_rs1_data(rs1_data),
    .i_less(less), .i_less_u(less_u), .i_zero(zero),
    .o_pc(o_pc)
  );

  npc_datamem u_datamem (
    .i_clk(i_clk), .i_rst_n(ret_valid),
    .i_addr(alu_result), .i_wdata(rs2_data), .i_wen(mem_wen),
    .o_rdata(mem_rdata)
  );

  assign wb_data = mem_to_reg ? mem_rdata : alu_result;

  assign o_ret_valid   = ret_valid;
  assign o_ret_pc      = o_pc;
  assign o_ret_inst    = i_inst;
  assign o_ret_illegal = illegal;
  assign o_ret_wen     = reg_wen & ret_valid;
  assign o_ret_rd      = rd;
  assign o_ret_wdata   = wb_data;

endmodule

`default_nettype wire
